// ==== rtl/alu_unit.sv ====
`timescale 1ns/10ps

module alu_unit
    import ooo_pkg::*;
(
    input  logic     clk_i,
    input  logic     arst_n_i,
    input  logic     iss_valid_i,
    input  alu_op_e  iss_op_i,
    input  data_t    iss_a_i,
    input  data_t    iss_b_i,
    input  rob_tag_t iss_tag_i,
    output logic     res_valid_o,
    output rob_tag_t res_tag_o,
    output data_t    res_data_o
);

    data_t result;

    always_comb begin
        case (iss_op_i)
            ALU_ADD: result = iss_a_i + iss_b_i;
            ALU_SUB: result = iss_a_i - iss_b_i;
            ALU_AND: result = iss_a_i & iss_b_i;
            ALU_OR:  result = iss_a_i | iss_b_i;
            ALU_XOR: result = iss_a_i ^ iss_b_i;
            ALU_SLL: result = iss_a_i << iss_b_i[4:0];
            ALU_SRL: result = iss_a_i >> iss_b_i[4:0];
            ALU_SLT: result = data_t'($signed(iss_a_i) < $signed(iss_b_i));
            default: result = '0;
        endcase
    end

    // broadcast strobe, one cycle after issue
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            res_valid_o <= 1'b0;
        end else begin
            res_valid_o <= iss_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (iss_valid_i) begin
            res_tag_o  <= iss_tag_i;
            res_data_o <= result;
        end
    end

endmodule

// ==== rtl/dispatch_ctrl.sv ====
`timescale 1ns/10ps

module dispatch_ctrl (
    input  logic clk_i,
    input  logic arst_n_i,
    input  logic disp_req_i,
    input  logic rob_full_i,
    input  logic rs_full_i,
    output logic disp_ack_o,
    output logic alloc_o
);

    typedef enum logic [1:0] {
        ST_IDLE  = 2'd0,
        ST_GRANT = 2'd1,
        ST_HOLD  = 2'd2
    } state_e;

    state_e state_q;
    state_e state_d;
    logic   room;

    // both the rob and the station need a free entry
    assign room = !rob_full_i && !rs_full_i;

    // allocation happens on the edge that raises ack
    assign alloc_o = (state_q == ST_IDLE) && disp_req_i && room;

    assign disp_ack_o = (state_q != ST_IDLE);

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (alloc_o) begin
                    state_d = ST_GRANT;
                end
            end
            ST_GRANT: begin
                if (disp_req_i) begin
                    state_d = ST_HOLD;
                end else begin
                    state_d = ST_IDLE;
                end
            end
            ST_HOLD: begin
                // wait for the source to release req
                if (!disp_req_i) begin
                    state_d = ST_IDLE;
                end
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

endmodule

// ==== rtl/ooo_backend.sv ====
`timescale 1ns/10ps
`include "ooo_config.svh"

module ooo_backend
    import ooo_pkg::*;
(
    input  logic     clk_i,
    input  logic     arst_n_i,
    input  logic     disp_req_i,
    input  alu_op_e  disp_op_i,
    input  reg_sel_t disp_rd_i,
    input  reg_sel_t disp_rs1_i,
    input  reg_sel_t disp_rs2_i,
    input  data_t    disp_imm_i,
    input  logic     disp_use_imm_i,
    output logic     disp_ack_o,
    output logic     commit_valid_o,
    output reg_sel_t commit_rd_o,
    output data_t    commit_data_o
);

    logic                  rob_full;
    logic                  rs_full;
    logic                  alloc;
    rob_tag_t              tail_tag;
    logic [`ROB_DEPTH-1:0] rob_done;
    data_t                 rob_data [`ROB_DEPTH];
    rob_tag_t              commit_tag;

    logic     src1_rdy;
    logic     src2_rdy;
    data_t    src1_val;
    data_t    src2_val;
    rob_tag_t src1_tag;
    rob_tag_t src2_tag;

    logic     iss_valid;
    alu_op_e  iss_op;
    data_t    iss_a;
    data_t    iss_b;
    rob_tag_t iss_tag;

    // alu broadcast
    logic     res_valid;
    rob_tag_t res_tag;
    data_t    res_data;

    dispatch_ctrl u_dispatch_ctrl (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .disp_req_i (disp_req_i),
        .rob_full_i (rob_full),
        .rs_full_i  (rs_full),
        .disp_ack_o (disp_ack_o),
        .alloc_o    (alloc)
    );

    rename_map u_rename_map (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .alloc_i        (alloc),
        .disp_rd_i      (disp_rd_i),
        .disp_rs1_i     (disp_rs1_i),
        .disp_rs2_i     (disp_rs2_i),
        .tail_tag_i     (tail_tag),
        .rob_done_i     (rob_done),
        .rob_data_i     (rob_data),
        .res_valid_i    (res_valid),
        .res_tag_i      (res_tag),
        .res_data_i     (res_data),
        .commit_valid_i (commit_valid_o),
        .commit_rd_i    (commit_rd_o),
        .commit_tag_i   (commit_tag),
        .commit_data_i  (commit_data_o),
        .src1_rdy_o     (src1_rdy),
        .src2_rdy_o     (src2_rdy),
        .src1_val_o     (src1_val),
        .src2_val_o     (src2_val),
        .src1_tag_o     (src1_tag),
        .src2_tag_o     (src2_tag)
    );

    rs_alu u_rs_alu (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .alloc_i        (alloc),
        .disp_op_i      (disp_op_i),
        .disp_imm_i     (disp_imm_i),
        .disp_use_imm_i (disp_use_imm_i),
        .src1_rdy_i     (src1_rdy),
        .src2_rdy_i     (src2_rdy),
        .src1_val_i     (src1_val),
        .src2_val_i     (src2_val),
        .src1_tag_i     (src1_tag),
        .src2_tag_i     (src2_tag),
        .tail_tag_i     (tail_tag),
        .res_valid_i    (res_valid),
        .res_tag_i      (res_tag),
        .res_data_i     (res_data),
        .rs_full_o      (rs_full),
        .iss_valid_o    (iss_valid),
        .iss_op_o       (iss_op),
        .iss_a_o        (iss_a),
        .iss_b_o        (iss_b),
        .iss_tag_o      (iss_tag)
    );

    alu_unit u_alu_unit (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .iss_valid_i (iss_valid),
        .iss_op_i    (iss_op),
        .iss_a_i     (iss_a),
        .iss_b_i     (iss_b),
        .iss_tag_i   (iss_tag),
        .res_valid_o (res_valid),
        .res_tag_o   (res_tag),
        .res_data_o  (res_data)
    );

    rob u_rob (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .alloc_i        (alloc),
        .disp_rd_i      (disp_rd_i),
        .res_valid_i    (res_valid),
        .res_tag_i      (res_tag),
        .res_data_i     (res_data),
        .tail_tag_o     (tail_tag),
        .rob_full_o     (rob_full),
        .rob_done_o     (rob_done),
        .rob_data_o     (rob_data),
        .commit_valid_o (commit_valid_o),
        .commit_rd_o    (commit_rd_o),
        .commit_tag_o   (commit_tag),
        .commit_data_o  (commit_data_o)
    );

endmodule

// ==== rtl/ooo_config.svh ====
`ifndef OOO_CONFIG_SVH
`define OOO_CONFIG_SVH

// operand and result width
`define DATA_LEN 32

// architectural registers, x0 reads as zero
`define REG_NUM 32
`define REG_SEL 5

// reorder buffer, index doubles as rename tag
`define ROB_DEPTH 8
`define ROB_SEL 3

// alu reservation station slots
`define RS_DEPTH 4

`endif

// ==== rtl/ooo_pkg.sv ====
`include "ooo_config.svh"

package ooo_pkg;

    // one machine word
    typedef logic [`DATA_LEN-1:0] data_t;

    // architectural register number
    typedef logic [`REG_SEL-1:0] reg_sel_t;

    // rename tag, same as the rob index
    typedef logic [`ROB_SEL-1:0] rob_tag_t;

    // alu operations
    // shifts take the low 5 bits of operand b, slt compares signed
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLL = 3'd5,
        ALU_SRL = 3'd6,
        ALU_SLT = 3'd7
    } alu_op_e;

endpackage

// ==== rtl/rename_map.sv ====
`timescale 1ns/10ps
`include "ooo_config.svh"

module rename_map
    import ooo_pkg::*;
(
    input  logic                 clk_i,
    input  logic                 arst_n_i,
    input  logic                 alloc_i,
    input  reg_sel_t             disp_rd_i,
    input  reg_sel_t             disp_rs1_i,
    input  reg_sel_t             disp_rs2_i,
    input  rob_tag_t             tail_tag_i,
    input  logic [`ROB_DEPTH-1:0] rob_done_i,
    input  data_t                rob_data_i [`ROB_DEPTH],
    input  logic                 res_valid_i,
    input  rob_tag_t             res_tag_i,
    input  data_t                res_data_i,
    input  logic                 commit_valid_i,
    input  reg_sel_t             commit_rd_i,
    input  rob_tag_t             commit_tag_i,
    input  data_t                commit_data_i,
    output logic                 src1_rdy_o,
    output logic                 src2_rdy_o,
    output data_t                src1_val_o,
    output data_t                src2_val_o,
    output rob_tag_t             src1_tag_o,
    output rob_tag_t             src2_tag_o
);

    data_t    arf_q  [`REG_NUM];
    rob_tag_t tag_q  [`REG_NUM];
    logic [`REG_NUM-1:0] busy_q;

    // value from arf, finished rob entry or the broadcast, else a tag
    function automatic void resolve(
        input  reg_sel_t rs,
        output logic     rdy,
        output data_t    val,
        output rob_tag_t tag
    );
        rob_tag_t t;
        t   = tag_q[rs];
        tag = t;
        rdy = 1'b1;
        if (rs == '0) begin
            val = '0;
        end else if (!busy_q[rs]) begin
            val = arf_q[rs];
        end else if (rob_done_i[t]) begin
            val = rob_data_i[t];
        end else if (res_valid_i && res_tag_i == t) begin
            val = res_data_i;
        end else begin
            val = '0;
            rdy = 1'b0;
        end
    endfunction

    always_comb begin
        resolve(disp_rs1_i, src1_rdy_o, src1_val_o, src1_tag_o);
        resolve(disp_rs2_i, src2_rdy_o, src2_val_o, src2_tag_o);
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            busy_q <= '0;
            for (int i = 0; i < `REG_NUM; i++) begin
                arf_q[i] <= '0;
            end
        end else begin
            if (commit_valid_i && commit_rd_i != '0) begin
                arf_q[commit_rd_i] <= commit_data_i;
                if (tag_q[commit_rd_i] == commit_tag_i) begin
                    busy_q[commit_rd_i] <= 1'b0;
                end
            end
            // a new mapping of the same register overrides the clear
            if (alloc_i && disp_rd_i != '0) begin
                busy_q[disp_rd_i] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (alloc_i && disp_rd_i != '0) begin
            tag_q[disp_rd_i] <= tail_tag_i;
        end
    end

endmodule

// ==== rtl/rob.sv ====
`timescale 1ns/10ps
`include "ooo_config.svh"

module rob
    import ooo_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  arst_n_i,
    input  logic                  alloc_i,
    input  reg_sel_t              disp_rd_i,
    input  logic                  res_valid_i,
    input  rob_tag_t              res_tag_i,
    input  data_t                 res_data_i,
    output rob_tag_t              tail_tag_o,
    output logic                  rob_full_o,
    output logic [`ROB_DEPTH-1:0] rob_done_o,
    output data_t                 rob_data_o [`ROB_DEPTH],
    output logic                  commit_valid_o,
    output reg_sel_t              commit_rd_o,
    output rob_tag_t              commit_tag_o,
    output data_t                 commit_data_o
);

    rob_tag_t             head_q;
    rob_tag_t             tail_q;
    logic [`ROB_SEL:0]    count_q;
    logic [`ROB_DEPTH-1:0] done_q;
    reg_sel_t             rd_q   [`ROB_DEPTH];
    data_t                data_q [`ROB_DEPTH];

    assign tail_tag_o = tail_q;
    assign rob_full_o = (count_q == (`ROB_SEL+1)'(`ROB_DEPTH));
    assign rob_done_o = done_q;
    assign rob_data_o = data_q;

    // head retires as soon as it is finished
    assign commit_valid_o = (count_q != '0) && done_q[head_q];
    assign commit_rd_o    = rd_q[head_q];
    assign commit_tag_o   = head_q;
    assign commit_data_o  = data_q[head_q];

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
            done_q  <= '0;
        end else begin
            if (res_valid_i) begin
                done_q[res_tag_i] <= 1'b1;
            end
            if (alloc_i) begin
                done_q[tail_q] <= 1'b0;
                tail_q         <= tail_q + 1'b1;
            end
            if (commit_valid_o) begin
                head_q <= head_q + 1'b1;
            end
            count_q <= count_q + (`ROB_SEL+1)'(alloc_i)
                     - (`ROB_SEL+1)'(commit_valid_o);
        end
    end

    always_ff @(posedge clk_i) begin
        if (alloc_i) begin
            rd_q[tail_q] <= disp_rd_i;
        end
        if (res_valid_i) begin
            data_q[res_tag_i] <= res_data_i;
        end
    end

endmodule

// ==== rtl/rs_alu.sv ====
`timescale 1ns/10ps
`include "ooo_config.svh"

module rs_alu
    import ooo_pkg::*;
(
    input  logic     clk_i,
    input  logic     arst_n_i,
    input  logic     alloc_i,
    input  alu_op_e  disp_op_i,
    input  data_t    disp_imm_i,
    input  logic     disp_use_imm_i,
    input  logic     src1_rdy_i,
    input  logic     src2_rdy_i,
    input  data_t    src1_val_i,
    input  data_t    src2_val_i,
    input  rob_tag_t src1_tag_i,
    input  rob_tag_t src2_tag_i,
    input  rob_tag_t tail_tag_i,
    input  logic     res_valid_i,
    input  rob_tag_t res_tag_i,
    input  data_t    res_data_i,
    output logic     rs_full_o,
    output logic     iss_valid_o,
    output alu_op_e  iss_op_o,
    output data_t    iss_a_o,
    output data_t    iss_b_o,
    output rob_tag_t iss_tag_o
);

    localparam int SLOT_W = $clog2(`RS_DEPTH);

    logic [`RS_DEPTH-1:0] valid_q;
    logic [SLOT_W-1:0]    age_q [`RS_DEPTH];
    alu_op_e              op_q  [`RS_DEPTH];
    data_t                a_val_q [`RS_DEPTH];
    data_t                b_val_q [`RS_DEPTH];
    rob_tag_t             a_tag_q [`RS_DEPTH];
    rob_tag_t             b_tag_q [`RS_DEPTH];
    rob_tag_t             dst_q   [`RS_DEPTH];
    logic [`RS_DEPTH-1:0] a_rdy_q;
    logic [`RS_DEPTH-1:0] b_rdy_q;
    logic [`RS_DEPTH-1:0] ready;

    logic              iss_fire;
    logic [SLOT_W-1:0] iss_idx;
    logic [SLOT_W-1:0] iss_age;
    logic [SLOT_W-1:0] free_idx;

    assign ready     = valid_q & a_rdy_q & b_rdy_q;
    assign rs_full_o = &valid_q;

    // lowest free slot
    always_comb begin
        free_idx = '0;
        for (int i = `RS_DEPTH - 1; i >= 0; i--) begin
            if (!valid_q[i]) begin
                free_idx = SLOT_W'(i);
            end
        end
    end

    // oldest ready entry has the largest age
    always_comb begin
        iss_fire = 1'b0;
        iss_idx  = '0;
        iss_age  = '0;
        for (int i = 0; i < `RS_DEPTH; i++) begin
            if (ready[i] && (!iss_fire || age_q[i] > iss_age)) begin
                iss_fire = 1'b1;
                iss_idx  = SLOT_W'(i);
                iss_age  = age_q[i];
            end
        end
    end

    assign iss_valid_o = iss_fire;
    assign iss_op_o    = op_q[iss_idx];
    assign iss_a_o     = a_val_q[iss_idx];
    assign iss_b_o     = b_val_q[iss_idx];
    assign iss_tag_o   = dst_q[iss_idx];

    // ages stay a dense 0..n-1 order over the valid slots
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= '0;
            for (int i = 0; i < `RS_DEPTH; i++) begin
                age_q[i] <= '0;
            end
        end else begin
            for (int i = 0; i < `RS_DEPTH; i++) begin
                if (valid_q[i]) begin
                    age_q[i] <= age_q[i] + SLOT_W'(alloc_i)
                              - SLOT_W'(iss_fire && age_q[i] > iss_age);
                end
            end
            if (iss_fire) begin
                valid_q[iss_idx] <= 1'b0;
            end
            if (alloc_i) begin
                valid_q[free_idx] <= 1'b1;
                age_q[free_idx]   <= '0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        // wakeup from the alu broadcast
        for (int i = 0; i < `RS_DEPTH; i++) begin
            if (res_valid_i && !a_rdy_q[i] && a_tag_q[i] == res_tag_i) begin
                a_val_q[i] <= res_data_i;
                a_rdy_q[i] <= 1'b1;
            end
            if (res_valid_i && !b_rdy_q[i] && b_tag_q[i] == res_tag_i) begin
                b_val_q[i] <= res_data_i;
                b_rdy_q[i] <= 1'b1;
            end
        end
        if (alloc_i) begin
            op_q[free_idx]    <= disp_op_i;
            dst_q[free_idx]   <= tail_tag_i;
            a_val_q[free_idx] <= src1_val_i;
            a_rdy_q[free_idx] <= src1_rdy_i;
            a_tag_q[free_idx] <= src1_tag_i;
            b_tag_q[free_idx] <= src2_tag_i;
            if (disp_use_imm_i) begin
                b_val_q[free_idx] <= disp_imm_i;
                b_rdy_q[free_idx] <= 1'b1;
            end else begin
                b_val_q[free_idx] <= src2_val_i;
                b_rdy_q[free_idx] <= src2_rdy_i;
            end
        end
    end

endmodule

// ==== tb.f ====
+incdir+rtl
rtl/ooo_pkg.sv
rtl/dispatch_ctrl.sv
rtl/rename_map.sv
rtl/rs_alu.sv
rtl/alu_unit.sv
rtl/rob.sv
rtl/ooo_backend.sv
test/ooo_backend_sva.sv
test/tb_ooo_backend.sv

// ==== test/ooo_backend_sva.sv ====
`timescale 1ns/10ps

module ooo_backend_sva
    import ooo_pkg::*;
(
    input logic     clk_i,
    input logic     arst_n_i,
    input logic     disp_req_i,
    input logic     disp_ack_i,
    input logic     commit_valid_i,
    input rob_tag_t commit_tag_i
);

    int assert_fails = 0;

    // ack only rises on a held request
    ack_rise_with_req: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        $rose(disp_ack_i) |-> disp_req_i)
    else begin
        assert_fails++;
        $error("dispatch ack rose without a request");
    end

    ack_fall_after_req: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        $fell(disp_ack_i) |-> !$past(disp_req_i))
    else begin
        assert_fails++;
        $error("dispatch ack fell while the request was still high");
    end

    // released request drops ack on the next cycle
    ack_release: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        disp_ack_i && !disp_req_i |=> !disp_ack_i)
    else begin
        assert_fails++;
        $error("dispatch ack held after the request fell");
    end

    commit_no_repeat: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        commit_valid_i && $past(commit_valid_i) |-> commit_tag_i != $past(commit_tag_i))
    else begin
        assert_fails++;
        $error("same reorder buffer tag committed twice in a row");
    end

endmodule

bind ooo_backend ooo_backend_sva u_sva (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .disp_req_i     (disp_req_i),
    .disp_ack_i     (disp_ack_o),
    .commit_valid_i (commit_valid_o),
    .commit_tag_i   (commit_tag)
);

// ==== test/tb_ooo_backend.sv ====
`timescale 1ns/10ps
`include "ooo_config.svh"

module tb_ooo_backend
    import ooo_pkg::*;
();

    localparam int ACK_LIMIT   = 200;
    localparam int DRAIN_LIMIT = 1000;

    logic     clk;
    logic     arst_n;
    logic     disp_req;
    alu_op_e  disp_op;
    reg_sel_t disp_rd;
    reg_sel_t disp_rs1;
    reg_sel_t disp_rs2;
    data_t    disp_imm;
    logic     disp_use_imm;
    logic     disp_ack;
    logic     commit_valid;
    reg_sel_t commit_rd;
    data_t    commit_data;

    logic [31:0] lfsr;
    data_t       arch [`REG_NUM];
    reg_sel_t    recent [4];
    reg_sel_t    exp_rd_q [$];
    data_t       exp_data_q [$];
    logic [7:0]  ops_seen;
    logic        timed_out;
    int          dispatched = 0;
    int          committed = 0;
    int          errors = 0;
    int          checks = 0;
    int          tests = 0;

    ooo_backend UUT (
        .clk_i          (clk),
        .arst_n_i       (arst_n),
        .disp_req_i     (disp_req),
        .disp_op_i      (disp_op),
        .disp_rd_i      (disp_rd),
        .disp_rs1_i     (disp_rs1),
        .disp_rs2_i     (disp_rs2),
        .disp_imm_i     (disp_imm),
        .disp_use_imm_i (disp_use_imm),
        .disp_ack_o     (disp_ack),
        .commit_valid_o (commit_valid),
        .commit_rd_o    (commit_rd),
        .commit_data_o  (commit_data)
    );

    always #4 clk = ~clk;

    // x^32 + x^22 + x^2 + x + 1, one step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] val;
        logic        fb;
        int          k;
        val = '0;
        for (k = 0; k < n; k++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            val  = {val[30:0], fb};
        end
        return val;
    endfunction

    // mostly a recent destination when building chains
    function automatic reg_sel_t pick_src(input logic dep);
        if (dep && take_bits(2) != 0) begin
            return recent[take_bits(2)];
        end
        return reg_sel_t'(take_bits(5));
    endfunction

    function automatic data_t model_result(input alu_op_e op, input data_t a, input data_t b);
        logic [4:0] sh;
        sh = b[4:0];
        case (op)
            ALU_ADD: return a + b;
            ALU_SUB: return a + ~b + 1'b1;
            ALU_AND: return a & b;
            ALU_OR:  return a | b;
            ALU_XOR: return a ^ b;
            ALU_SLL: return a << sh;
            ALU_SRL: return a >> sh;
            default: begin
                // signed less-than, sign bits decide when they differ
                if (a[`DATA_LEN-1] != b[`DATA_LEN-1]) begin
                    return data_t'(a[`DATA_LEN-1]);
                end
                return data_t'(a < b);
            end
        endcase
    endfunction

    task automatic compare_bit(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            $display("mismatch at time %0t: %s is %b, expected %b", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic compare_rd(input reg_sel_t got, input reg_sel_t exp, input string what);
        checks++;
        if (got !== exp) begin
            $display("mismatch at time %0t: %s is %0d, expected %0d", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic compare_data(input data_t got, input data_t exp, input string what);
        checks++;
        if (got !== exp) begin
            $display("mismatch at time %0t: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic finish_test(input string name, input int errs_before);
        tests++;
        if (errors == errs_before) begin
            $display("test %0d %s: ok", tests, name);
        end else begin
            $display("test %0d %s: %0d errors", tests, name, errors - errs_before);
        end
    endtask

    // one four-phase transfer, model updated when ack is seen
    task automatic send_instr(input alu_op_e op, input reg_sel_t rd, input reg_sel_t rs1,
                              input reg_sel_t rs2, input data_t imm, input logic use_imm,
                              input int gap);
        int    waited;
        data_t res;
        int    k;
        if (timed_out) begin
            return;
        end
        repeat (gap) @(posedge clk);
        @(posedge clk);
        disp_req     <= 1'b1;
        disp_op      <= op;
        disp_rd      <= rd;
        disp_rs1     <= rs1;
        disp_rs2     <= rs2;
        disp_imm     <= imm;
        disp_use_imm <= use_imm;
        waited = 0;
        @(negedge clk);
        while (!disp_ack) begin
            if (waited == ACK_LIMIT) begin
                $display("timeout: request not acknowledged within %0d cycles", ACK_LIMIT);
                errors++;
                timed_out = 1'b1;
                return;
            end
            waited++;
            @(negedge clk);
        end
        res = model_result(op, arch[rs1], use_imm ? imm : arch[rs2]);
        exp_rd_q.push_back(rd);
        exp_data_q.push_back(res);
        dispatched++;
        ops_seen[op] = 1'b1;
        if (rd != '0) begin
            arch[rd] = res;
            for (k = 3; k > 0; k--) begin
                recent[k] = recent[k-1];
            end
            recent[0] = rd;
        end
        @(posedge clk);
        disp_req <= 1'b0;
        waited = 0;
        @(negedge clk);
        while (disp_ack) begin
            if (waited == ACK_LIMIT) begin
                $display("timeout: ack still high %0d cycles after req fell", ACK_LIMIT);
                errors++;
                timed_out = 1'b1;
                return;
            end
            waited++;
            @(negedge clk);
        end
    endtask

    task automatic drain();
        int waited;
        if (timed_out) begin
            return;
        end
        waited = 0;
        @(posedge clk);
        while (committed != dispatched) begin
            if (waited == DRAIN_LIMIT) begin
                $display("timeout: only %0d of %0d instructions committed",
                         committed, dispatched);
                errors++;
                timed_out = 1'b1;
                return;
            end
            waited++;
            @(posedge clk);
        end
    endtask

    task automatic check_reset();
        int errs_before;
        errs_before = errors;
        repeat (16) begin
            @(negedge clk);
            compare_bit(disp_ack, 1'b0, "disp_ack_o in reset");
            compare_bit(commit_valid, 1'b0, "commit_valid_o in reset");
        end
        @(posedge clk);
        arst_n <= 1'b1;
        repeat (4) begin
            @(negedge clk);
            compare_bit(disp_ack, 1'b0, "disp_ack_o after reset");
            compare_bit(commit_valid, 1'b0, "commit_valid_o after reset");
        end
        send_instr(ALU_ADD, 5'd1, 5'd0, 5'd0, 32'h0000_1234, 1'b1, 0);
        drain();
        finish_test("reset and first request", errs_before);
    endtask

    // mode 0 random, 1 dependent chains, 2 heavy use of x0
    task automatic run_batch(input string name, input int n, input int mode);
        int       errs_before;
        int       i;
        int       gap;
        alu_op_e  op;
        reg_sel_t rd;
        reg_sel_t rs1;
        reg_sel_t rs2;
        data_t    imm;
        logic     use_imm;
        errs_before = errors;
        ops_seen    = '0;
        for (i = 0; i < n; i++) begin
            op      = alu_op_e'(take_bits(3));
            rd      = reg_sel_t'(take_bits(5));
            rs1     = pick_src(mode != 0);
            rs2     = pick_src(mode != 0);
            use_imm = (take_bits(2) == 0);
            imm     = take_bits(32);
            if (mode == 0) begin
                gap = take_bits(2);
            end else begin
                gap = (take_bits(3) == 0) ? 1 : 0;
            end
            if (mode == 2) begin
                if (take_bits(1)) begin
                    rd = '0;
                end
                if (take_bits(1)) begin
                    rs1 = '0;
                end
                if (take_bits(2) == 0) begin
                    rs2 = '0;
                end
            end
            send_instr(op, rd, rs1, rs2, imm, use_imm, gap);
        end
        drain();
        if (mode == 0 && !timed_out && ops_seen != 8'hff) begin
            $display("not every ALU operation was dispatched, seen mask %b", ops_seen);
            errors++;
        end
        finish_test(name, errs_before);
    endtask

    task automatic check_counts();
        int errs_before;
        errs_before = errors;
        checks += 3;
        if (committed != dispatched) begin
            $display("%0d commits seen for %0d acknowledged dispatches", committed, dispatched);
            errors++;
        end
        if (exp_rd_q.size() != 0) begin
            $display("%0d expected commits never arrived", exp_rd_q.size());
            errors++;
        end
        if (UUT.u_sva.assert_fails != 0) begin
            $display("%0d assertion failures in the bound checker", UUT.u_sva.assert_fails);
            errors++;
        end
        finish_test("commit order and count", errs_before);
    endtask

    // commit monitor against the in-order queue
    always @(negedge clk) begin
        if (arst_n && commit_valid) begin
            committed++;
            if (exp_rd_q.size() == 0) begin
                $display("commit to rd %0d arrived with no instruction outstanding", commit_rd);
                errors++;
            end else begin
                compare_rd(commit_rd, exp_rd_q.pop_front(), "commit rd");
                compare_data(commit_data, exp_data_q.pop_front(), "commit data");
            end
        end
    end

    initial begin
        clk          = 1'b0;
        arst_n       = 1'b0;
        disp_req     = 1'b0;
        disp_op      = ALU_ADD;
        disp_rd      = '0;
        disp_rs1     = '0;
        disp_rs2     = '0;
        disp_imm     = '0;
        disp_use_imm = 1'b0;
        lfsr         = 32'h60ed4af8;
        timed_out    = 1'b0;
        ops_seen     = '0;
        for (int r = 0; r < `REG_NUM; r++) begin
            arch[r] = '0;
        end
        for (int r = 0; r < 4; r++) begin
            recent[r] = reg_sel_t'(r + 1);
        end
        check_reset();
        run_batch("random instructions", 200, 0);
        run_batch("dependent chains", 150, 1);
        run_batch("register zero", 60, 2);
        check_counts();
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule
